/* hdl/ide_bus_exec.sv */
// IDE bus strobe sequencer

module ide_bus_exec
#(
   parameter int T_SETUP   = 2,
   parameter int T_ACTIVE  = 3,
   parameter int T_RECOVER = 2
)
(
   input  logic             clk,
   input  logic             rst,
   input  logic             op_start,
   input  ide_pkg::bus_op_t op,
   input  logic [15:0]      ide_rdata,
   output logic             word_done,
   output ide_pkg::bus_op_t done_op,
   output logic [15:0]      rdata,
   output logic [1:0]       ide_cs,
   output logic [2:0]       ide_da,
   output logic             ide_dior,
   output logic             ide_diow,
   output logic [15:0]      ide_wdata
);

   // counter has to hold the longest phase.
   localparam int T_MAX_SA = (T_SETUP > T_ACTIVE) ? T_SETUP : T_ACTIVE;
   localparam int T_MAX    = (T_MAX_SA > T_RECOVER) ? T_MAX_SA : T_RECOVER;
   localparam int CNT_W    = $clog2(T_MAX + 1);

   typedef enum logic [1:0] {
      PH_IDLE,
      PH_SETUP,
      PH_ACTIVE,
      PH_RECOVER
   } phase_e;

   phase_e             phase;
   logic [CNT_W-1:0]   cnt;
   ide_pkg::bus_op_t   op_q;
   logic               in_op;

   // ------------------------------------------------------------------------
   // phase counter
   // ------------------------------------------------------------------------

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         phase     <= PH_IDLE;
         cnt       <= '0;
         word_done <= 1'b0;
      end
      else
      begin
         word_done <= 1'b0;
         case (phase)
            PH_IDLE:
            begin
               if (op_start)
               begin
                  phase <= PH_SETUP;
                  cnt   <= CNT_W'(T_SETUP - 1);
               end
            end
            PH_SETUP:
            begin
               if (cnt == '0)
               begin
                  phase <= PH_ACTIVE;
                  cnt   <= CNT_W'(T_ACTIVE - 1);
               end
               else
                  cnt <= cnt - 1'b1;
            end
            PH_ACTIVE:
            begin
               if (cnt == '0)
               begin
                  phase <= PH_RECOVER;
                  cnt   <= CNT_W'(T_RECOVER - 1);
               end
               else
                  cnt <= cnt - 1'b1;
            end
            default:
            begin
               if (cnt == '0)
               begin
                  phase     <= PH_IDLE;
                  word_done <= 1'b1;
               end
               else
                  cnt <= cnt - 1'b1;
            end
         endcase
      end
   end

   // latch the operation and capture the read word.
   always_ff @(posedge clk)
   begin
      if (phase == PH_IDLE && op_start)
         op_q <= op;
      // sample on the last low cycle of a read.
      if (phase == PH_ACTIVE && cnt == '0 && !op_q.wr)
         rdata <= ide_rdata;
   end

   // ------------------------------------------------------------------------
   // bus lines
   // ------------------------------------------------------------------------

   assign in_op     = (phase != PH_IDLE);
   assign ide_cs    = in_op ? op_q.cs : 2'b11;
   assign ide_da    = in_op ? op_q.da : 3'd0;
   assign ide_wdata = in_op ? op_q.wdata : 16'h0000;
   assign ide_dior  = !(phase == PH_ACTIVE && !op_q.wr);
   assign ide_diow  = !(phase == PH_ACTIVE && op_q.wr);
   assign done_op   = op_q;

endmodule

/* hdl/ide_cmd_decode.sv */
// IDE command decoder

module ide_cmd_decode
(
   input  logic              clk,
   input  logic              rst,
   input  logic              cmd_valid,
   input  ide_pkg::ide_cmd_u cmd,
   input  logic              word_done,
   input  logic              done_last,
   output logic              busy,
   output logic              op_start,
   output ide_pkg::bus_op_t  op
);

   ide_pkg::ide_cmd_u cmd_q;
   logic [7:0]        idx;
   logic              is_blk;

   // ------------------------------------------------------------------------
   // command sequencing
   // ------------------------------------------------------------------------

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         busy     <= 1'b0;
         op_start <= 1'b0;
         idx      <= 8'd0;
      end
      else
      begin
         op_start <= 1'b0;
         if (!busy && cmd_valid)
         begin
            busy     <= 1'b1;
            op_start <= 1'b1;
            idx      <= 8'd0;
         end
         else if (busy && word_done)
         begin
            if (done_last)
               busy <= 1'b0;
            else
            begin
               op_start <= 1'b1;
               idx      <= idx + 8'd1;
            end
         end
      end
   end

   // command word latched at acceptance.
   always_ff @(posedge clk)
   begin
      if (!busy && cmd_valid)
         cmd_q <= cmd;
   end

   // ------------------------------------------------------------------------
   // bus operation for the current word
   // ------------------------------------------------------------------------

   assign is_blk = (cmd_q.r.opcode == ide_pkg::OP_BLK_RD) ||
                   (cmd_q.r.opcode == ide_pkg::OP_BLK_WR);

   always_comb
   begin
      op = '0;
      if (is_blk)
      begin
         op.wr    = (cmd_q.b.opcode == ide_pkg::OP_BLK_WR);
         op.cs    = ide_pkg::CS_TASKFILE;
         op.da    = ide_pkg::REG_DATA;
         op.wdata = cmd_q.b.start + {8'h00, idx};
         op.index = idx;
         op.last  = (idx == cmd_q.b.count_m1);
      end
      else
      begin
         op.wr    = (cmd_q.r.opcode == ide_pkg::OP_REG_WR);
         op.cs    = cmd_q.r.cs;
         op.da    = cmd_q.r.da;
         op.wdata = cmd_q.r.data;
         op.index = 8'd0;
         op.last  = 1'b1;
      end
   end

endmodule

/* hdl/ide_device.sv */
// IDE device model

module ide_device
#(
   parameter int BUF_WORDS = 256
)
(
   input  logic        clk,
   input  logic        rst,
   input  logic [1:0]  ide_cs,
   input  logic [2:0]  ide_da,
   input  logic        ide_dior,
   input  logic        ide_diow,
   input  logic [15:0] ide_wdata,
   output logic [15:0] ide_rdata
);

   localparam int PTR_W = $clog2(BUF_WORDS);

   logic [15:0]    buf_mem [BUF_WORDS];
   logic [7:0]     tf_reg [1:6];
   logic [PTR_W:0] ptr;
   logic           ptr_full;
   logic           dior_q;
   logic           diow_q;
   logic           sel;
   logic           rd_rise;
   logic           wr_rise;
   logic           data_sel;

   // ------------------------------------------------------------------------
   // strobe edges
   // ------------------------------------------------------------------------

   assign sel      = (ide_cs == ide_pkg::CS_TASKFILE);
   assign data_sel = sel && (ide_da == ide_pkg::REG_DATA);
   assign ptr_full = (ptr == (PTR_W + 1)'(BUF_WORDS));

   // lines are still held on the cycle the strobe goes back high.
   assign rd_rise  = !dior_q && ide_dior;
   assign wr_rise  = !diow_q && ide_diow;

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         dior_q <= 1'b1;
         diow_q <= 1'b1;
      end
      else
      begin
         dior_q <= ide_dior;
         diow_q <= ide_diow;
      end
   end

   // ------------------------------------------------------------------------
   // task file and buffer pointer
   // ------------------------------------------------------------------------

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         ptr <= '0;
         for (int i = 1; i <= 6; i++)
            tf_reg[i] <= 8'h00;
      end
      else
      begin
         if (sel && wr_rise)
         begin
            case (ide_da)
               ide_pkg::REG_DATA:
               begin
                  if (!ptr_full)
                     ptr <= ptr + 1'b1;
               end
               ide_pkg::REG_CMD_STATUS:
                  ptr <= '0;
               default:
                  tf_reg[ide_da] <= ide_wdata[7:0];
            endcase
         end
         else if (data_sel && rd_rise && !ptr_full)
            ptr <= ptr + 1'b1;
      end
   end

   // sector buffer.
   always_ff @(posedge clk)
   begin
      if (data_sel && wr_rise && !ptr_full)
         buf_mem[ptr[PTR_W-1:0]] <= ide_wdata;
   end

   // ------------------------------------------------------------------------
   // read path
   // ------------------------------------------------------------------------

   always_comb
   begin
      ide_rdata = 16'h0000;
      if (sel && !ide_dior)
      begin
         case (ide_da)
            ide_pkg::REG_DATA:
            begin
               if (!ptr_full)
                  ide_rdata = buf_mem[ptr[PTR_W-1:0]];
            end
            ide_pkg::REG_CMD_STATUS:
            begin
               if (ptr_full)
                  ide_rdata = {8'h00, ide_pkg::STATUS_IDLE};
               else
                  ide_rdata = {8'h00, ide_pkg::STATUS_DRQ};
            end
            default:
               ide_rdata = {8'h00, tf_reg[ide_da]};
         endcase
      end
   end

endmodule

/* hdl/ide_pkg.sv */
// IDE subsystem definitions

package ide_pkg;

   // ------------------------------------------------------------------------
   // command word
   // ------------------------------------------------------------------------

   typedef enum logic [1:0] {
      OP_REG_RD = 2'd0,
      OP_REG_WR = 2'd1,
      OP_BLK_RD = 2'd2,
      OP_BLK_WR = 2'd3
   } ide_op_e;

   // single register access.
   typedef struct packed {
      ide_op_e     opcode;
      logic [1:0]  cs;
      logic [2:0]  da;
      logic [8:0]  unused;
      logic [15:0] data;
   } ide_reg_view_t;

   // burst on the data register.
   typedef struct packed {
      ide_op_e     opcode;
      logic [5:0]  unused;
      logic [7:0]  count_m1;
      logic [15:0] start;
   } ide_blk_view_t;

   // opcode sits in the same bits in both views.
   typedef union packed {
      ide_reg_view_t r;
      ide_blk_view_t b;
   } ide_cmd_u;

   // ------------------------------------------------------------------------
   // internal records
   // ------------------------------------------------------------------------

   typedef struct packed {
      logic        wr;
      logic [1:0]  cs;
      logic [2:0]  da;
      logic [15:0] wdata;
      logic [7:0]  index;
      logic        last;
   } bus_op_t;

   typedef struct packed {
      logic [15:0] data;
      logic [7:0]  index;
      logic        last;
   } result_t;

   // task file map with active low selects.
   localparam logic [2:0] REG_DATA       = 3'd0;
   localparam logic [2:0] REG_CMD_STATUS = 3'd7;
   localparam logic [1:0] CS_TASKFILE    = 2'b10;
   localparam logic [7:0] STATUS_DRQ     = 8'h58;
   localparam logic [7:0] STATUS_IDLE    = 8'h50;

endpackage

/* hdl/ide_result.sv */
// IDE result collector

module ide_result
(
   input  logic             clk,
   input  logic             rst,
   input  logic             word_done,
   input  ide_pkg::bus_op_t done_op,
   input  logic [15:0]      rdata,
   output logic             res_valid,
   output ide_pkg::result_t res,
   output logic             done,
   output logic [15:0]      checksum
);

   logic        rd_word;
   logic [15:0] sum_base;
   logic [15:0] sum_add;

   assign rd_word  = word_done && !done_op.wr;

   // index 0 opens a new command.
   assign sum_base = (done_op.index == 8'd0) ? 16'h0000 : checksum;
   assign sum_add  = done_op.wr ? 16'h0000 : rdata;

   // ------------------------------------------------------------------------
   // pulses and running sum
   // ------------------------------------------------------------------------

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         res_valid <= 1'b0;
         done      <= 1'b0;
         checksum  <= 16'h0000;
      end
      else
      begin
         res_valid <= rd_word;
         done      <= word_done && done_op.last;
         if (word_done)
            checksum <= sum_base + sum_add;
      end
   end

   // result record.
   always_ff @(posedge clk)
   begin
      if (rd_word)
      begin
         res.data  <= rdata;
         res.index <= done_op.index;
         res.last  <= done_op.last;
      end
   end

endmodule

/* hdl/ide_sub.sv */
// IDE bus subsystem top

module ide_sub
#(
   parameter int T_SETUP   = 2,
   parameter int T_ACTIVE  = 3,
   parameter int T_RECOVER = 2,
   parameter int BUF_WORDS = 256
)
(
   input  logic              clk,
   input  logic              rst,
   input  logic              cmd_valid,
   input  ide_pkg::ide_cmd_u cmd,
   output logic              busy,
   output logic              res_valid,
   output ide_pkg::result_t  res,
   output logic              done,
   output logic [15:0]       checksum
);

   // ------------------------------------------------------------------------
   // host stages
   // ------------------------------------------------------------------------

   logic             op_start;
   ide_pkg::bus_op_t op;
   logic             word_done;
   ide_pkg::bus_op_t done_op;
   logic [15:0]      rdata;

   // ide bus.
   logic [1:0]       ide_cs;
   logic [2:0]       ide_da;
   logic             ide_dior;
   logic             ide_diow;
   logic [15:0]      ide_wdata;
   logic [15:0]      ide_rdata;

   ide_cmd_decode i_ide_cmd_decode (
      .clk       (clk),
      .rst       (rst),
      .cmd_valid (cmd_valid),
      .cmd       (cmd),
      .word_done (word_done),
      .done_last (done_op.last),
      .busy      (busy),
      .op_start  (op_start),
      .op        (op)
   );

   ide_bus_exec #(
      .T_SETUP   (T_SETUP),
      .T_ACTIVE  (T_ACTIVE),
      .T_RECOVER (T_RECOVER)
   ) i_ide_bus_exec (
      .clk       (clk),
      .rst       (rst),
      .op_start  (op_start),
      .op        (op),
      .ide_rdata (ide_rdata),
      .word_done (word_done),
      .done_op   (done_op),
      .rdata     (rdata),
      .ide_cs    (ide_cs),
      .ide_da    (ide_da),
      .ide_dior  (ide_dior),
      .ide_diow  (ide_diow),
      .ide_wdata (ide_wdata)
   );

   ide_result i_ide_result (
      .clk       (clk),
      .rst       (rst),
      .word_done (word_done),
      .done_op   (done_op),
      .rdata     (rdata),
      .res_valid (res_valid),
      .res       (res),
      .done      (done),
      .checksum  (checksum)
   );

   // ------------------------------------------------------------------------
   // device side
   // ------------------------------------------------------------------------

   ide_device #(
      .BUF_WORDS (BUF_WORDS)
   ) i_ide_device (
      .clk       (clk),
      .rst       (rst),
      .ide_cs    (ide_cs),
      .ide_da    (ide_da),
      .ide_dior  (ide_dior),
      .ide_diow  (ide_diow),
      .ide_wdata (ide_wdata),
      .ide_rdata (ide_rdata)
   );

endmodule

/* ide_sub.f */
hdl/ide_pkg.sv
hdl/ide_cmd_decode.sv
hdl/ide_bus_exec.sv
hdl/ide_device.sv
hdl/ide_result.sv
hdl/ide_sub.sv
tests/tb_ide_sub.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Compile and run the IDE subsystem testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -j 0 \
   --top-module tb_ide_sub -f ide_sub.f \
   || { echo "verilator build failed"; exit 1; }

out="$(./obj_dir/Vtb_ide_sub)"
echo "$out"

grep -q "ALL TESTS PASSED" <<< "$out" \
   && { echo "simulation passed"; exit 0; } \
   || { echo "simulation failed"; exit 1; }

/* tests/tb_ide_sub.sv */
// IDE subsystem testbench

module tb_ide_sub;

   timeunit 1ns;
   timeprecision 100ps;

   localparam int T_SETUP    = 2;
   localparam int T_ACTIVE   = 3;
   localparam int T_RECOVER  = 2;
   localparam int BUF_WORDS  = 256;
   localparam int WAIT_LIMIT = (BUF_WORDS + 4) * (T_SETUP + T_ACTIVE + T_RECOVER + 1) * 2;

   logic              clk;
   logic              rst;
   logic              cmd_valid;
   ide_pkg::ide_cmd_u cmd;
   logic              busy;
   logic              res_valid;
   ide_pkg::result_t  res;
   logic              done;
   logic [15:0]       checksum;

   // reference model state.
   logic [15:0]       m_buf [BUF_WORDS];
   logic [7:0]        m_tf [8];
   int                m_ptr;
   ide_pkg::result_t  exp_q [$];
   ide_pkg::result_t  exp_res;
   logic [15:0]       exp_sum;
   logic [31:0]       lcg_state;

   int                res_cnt;
   int                done_cnt;
   int                chk_errs;
   int                misc_errs;

   ide_sub #(
      .T_SETUP   (T_SETUP),
      .T_ACTIVE  (T_ACTIVE),
      .T_RECOVER (T_RECOVER),
      .BUF_WORDS (BUF_WORDS)
   ) i_ide_sub (
      .clk       (clk),
      .rst       (rst),
      .cmd_valid (cmd_valid),
      .cmd       (cmd),
      .busy      (busy),
      .res_valid (res_valid),
      .res       (res),
      .done      (done),
      .checksum  (checksum)
   );

   initial
   begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // ------------------------------------------------------------------------
   // helpers
   // ------------------------------------------------------------------------

   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   function automatic ide_pkg::ide_cmd_u reg_cmd(ide_pkg::ide_op_e opc, logic [1:0] cs,
                                                 logic [2:0] da, logic [15:0] data);
      ide_pkg::ide_cmd_u c;
      c          = '0;
      c.r.opcode = opc;
      c.r.cs     = cs;
      c.r.da     = da;
      c.r.data   = data;
      return c;
   endfunction

   function automatic ide_pkg::ide_cmd_u blk_cmd(ide_pkg::ide_op_e opc, logic [7:0] count_m1,
                                                 logic [15:0] start);
      ide_pkg::ide_cmd_u c;
      c            = '0;
      c.b.opcode   = opc;
      c.b.count_m1 = count_m1;
      c.b.start    = start;
      return c;
   endfunction

   function automatic void expect_word(logic [15:0] v, int idx, logic last);
      ide_pkg::result_t r;
      r.data  = v;
      r.index = 8'(idx);
      r.last  = last;
      exp_q.push_back(r);
      exp_sum = exp_sum + v;
   endfunction

   // register read model with a pointer that saturates at the buffer size.
   function automatic logic [15:0] model_reg_rd(logic [1:0] cs, logic [2:0] da);
      logic [15:0] v;
      v = 16'h0000;
      if (cs == ide_pkg::CS_TASKFILE)
      begin
         if (da == ide_pkg::REG_DATA)
         begin
            if (m_ptr < BUF_WORDS)
            begin
               v = m_buf[m_ptr];
               m_ptr++;
            end
         end
         else if (da == ide_pkg::REG_CMD_STATUS)
            v = {8'h00, (m_ptr < BUF_WORDS) ? ide_pkg::STATUS_DRQ : ide_pkg::STATUS_IDLE};
         else
            v = {8'h00, m_tf[da]};
      end
      return v;
   endfunction

   function automatic void model_reg_wr(logic [1:0] cs, logic [2:0] da, logic [15:0] d);
      if (cs == ide_pkg::CS_TASKFILE)
      begin
         if (da == ide_pkg::REG_DATA)
         begin
            if (m_ptr < BUF_WORDS)
            begin
               m_buf[m_ptr] = d;
               m_ptr++;
            end
         end
         else if (da == ide_pkg::REG_CMD_STATUS)
            m_ptr = 0;
         else
            m_tf[da] = d[7:0];
      end
   endfunction

   // predicts results and checksum and returns the number of result pulses.
   function automatic int model_cmd(ide_pkg::ide_cmd_u c);
      int cnt;
      cnt     = int'(c.b.count_m1) + 1;
      exp_sum = 16'h0000;
      case (c.r.opcode)
         ide_pkg::OP_REG_RD:
         begin
            expect_word(model_reg_rd(c.r.cs, c.r.da), 0, 1'b1);
            return 1;
         end
         ide_pkg::OP_REG_WR:
            model_reg_wr(c.r.cs, c.r.da, c.r.data);
         ide_pkg::OP_BLK_RD:
         begin
            for (int i = 0; i < cnt; i++)
               expect_word(model_reg_rd(ide_pkg::CS_TASKFILE, ide_pkg::REG_DATA), i,
                           i == cnt - 1);
            return cnt;
         end
         default:
         begin
            for (int i = 0; i < cnt; i++)
               model_reg_wr(ide_pkg::CS_TASKFILE, ide_pkg::REG_DATA, c.b.start + 16'(i));
         end
      endcase
      return 0;
   endfunction

   // ------------------------------------------------------------------------
   // command driver
   // ------------------------------------------------------------------------

   task automatic run_cmd(input ide_pkg::ide_cmd_u c, input logic poke_en,
                          input ide_pkg::ide_cmd_u poke_cmd);
      int n_res;
      int res_before;
      int done_before;
      int cycles;
      n_res       = model_cmd(c);
      res_before  = res_cnt;
      done_before = done_cnt;
      cmd         = c;
      cmd_valid   = 1'b1;
      @(posedge clk);
      #1;
      cmd_valid = 1'b0;
      if (poke_en)
      begin
         cycles = 0;
         while (!busy && cycles < WAIT_LIMIT)
         begin
            @(posedge clk);
            #1;
            cycles++;
         end
         if (!busy)
         begin
            $display("t=%0t busy never rose after a command strobe", $time);
            misc_errs++;
         end
         // this strobe lands while busy and must be dropped.
         cmd       = poke_cmd;
         cmd_valid = 1'b1;
         @(posedge clk);
         #1;
         cmd_valid = 1'b0;
      end
      cycles = 0;
      while (done_cnt == done_before && cycles < WAIT_LIMIT)
      begin
         @(posedge clk);
         #1;
         cycles++;
      end
      if (done_cnt == done_before)
      begin
         $display("t=%0t timed out waiting for done", $time);
         misc_errs++;
      end
      // one more cycle makes a repeated done pulse visible.
      @(posedge clk);
      #1;
      assert (done_cnt - done_before == 1)
      else
      begin
         $display("CHECK FAILED t=%0t done count exp=1 got=%0d",
                  $time, done_cnt - done_before);
         chk_errs++;
      end
      assert (res_cnt - res_before == n_res)
      else
      begin
         $display("CHECK FAILED t=%0t res_valid count exp=%0d got=%0d",
                  $time, n_res, res_cnt - res_before);
         chk_errs++;
      end
      exp_q.delete();
   endtask

   // ------------------------------------------------------------------------
   // output checks
   // ------------------------------------------------------------------------

   always @(posedge clk)
   begin
      if (!rst)
      begin
         if (res_valid)
         begin
            assert (exp_q.size() > 0)
            else
            begin
               $display("t=%0t result pulsed with nothing expected", $time);
               misc_errs++;
            end
            if (exp_q.size() > 0)
            begin
               exp_res = exp_q.pop_front();
               assert (res == exp_res)
               else
               begin
                  $display("CHECK FAILED t=%0t res exp=%h got=%h", $time, exp_res, res);
                  chk_errs++;
               end
            end
            res_cnt++;
         end
         if (done)
         begin
            assert (checksum == exp_sum)
            else
            begin
               $display("CHECK FAILED t=%0t checksum exp=%h got=%h", $time, exp_sum, checksum);
               chk_errs++;
            end
            assert (!busy)
            else
            begin
               $display("CHECK FAILED t=%0t busy exp=0 got=%b", $time, busy);
               chk_errs++;
            end
            done_cnt++;
         end
      end
   end

   // ------------------------------------------------------------------------
   // stimulus
   // ------------------------------------------------------------------------

   initial
   begin
      logic [31:0] rnd;
      logic [7:0]  cnt_m1;
      logic [15:0] start;
      cmd_valid = 1'b0;
      cmd       = '0;
      rst       = 1'b1;
      lcg_state = 32'h7427_ccb0;
      m_ptr     = 0;
      exp_sum   = 16'h0000;
      res_cnt   = 0;
      done_cnt  = 0;
      chk_errs  = 0;
      misc_errs = 0;
      for (int i = 0; i < 8; i++)
         m_tf[i] = 8'h00;
      repeat (16) @(posedge clk);
      #1;
      rst = 1'b0;

      assert ({busy, res_valid, done} == 3'b000)
      else
      begin
         $display("CHECK FAILED t=%0t {busy,res_valid,done} exp=000 got=%b",
                  $time, {busy, res_valid, done});
         chk_errs++;
      end
      for (int r = 1; r <= 6; r++)
         run_cmd(reg_cmd(ide_pkg::OP_REG_RD, ide_pkg::CS_TASKFILE, 3'(r), 16'h0), 1'b0, '0);

      // task file keeps the low byte only.
      for (int r = 1; r <= 6; r++)
      begin
         rnd = lcg_next();
         run_cmd(reg_cmd(ide_pkg::OP_REG_WR, ide_pkg::CS_TASKFILE, 3'(r), rnd[31:16]),
                 1'b0, '0);
      end
      run_cmd(reg_cmd(ide_pkg::OP_REG_WR, 2'b01, 3'd2, 16'h5aa5), 1'b0, '0);
      run_cmd(reg_cmd(ide_pkg::OP_REG_RD, 2'b01, 3'd2, 16'h0), 1'b0, '0);
      for (int r = 1; r <= 6; r++)
         run_cmd(reg_cmd(ide_pkg::OP_REG_RD, ide_pkg::CS_TASKFILE, 3'(r), 16'h0), 1'b0, '0);

      for (int t = 0; t < 4; t++)
      begin
         rnd    = lcg_next();
         cnt_m1 = rnd[31:24];
         rnd    = lcg_next();
         start  = rnd[31:16];
         run_cmd(reg_cmd(ide_pkg::OP_REG_WR, ide_pkg::CS_TASKFILE, ide_pkg::REG_CMD_STATUS,
                         16'h0), 1'b0, '0);
         run_cmd(reg_cmd(ide_pkg::OP_REG_RD, ide_pkg::CS_TASKFILE, ide_pkg::REG_CMD_STATUS,
                         16'h0), 1'b0, '0);
         run_cmd(blk_cmd(ide_pkg::OP_BLK_WR, cnt_m1, start), 1'b0, '0);
         run_cmd(reg_cmd(ide_pkg::OP_REG_WR, ide_pkg::CS_TASKFILE, ide_pkg::REG_CMD_STATUS,
                         16'h0), 1'b0, '0);
         run_cmd(blk_cmd(ide_pkg::OP_BLK_RD, cnt_m1, start), t < 2,
                 (t == 0) ? reg_cmd(ide_pkg::OP_REG_WR, ide_pkg::CS_TASKFILE, 3'd3,
                                    {8'h00, ~m_tf[3]})
                          : blk_cmd(ide_pkg::OP_BLK_RD, 8'd3, 16'h0));
      end

      // filling the whole buffer sends the status to idle.
      rnd = lcg_next();
      run_cmd(reg_cmd(ide_pkg::OP_REG_WR, ide_pkg::CS_TASKFILE, ide_pkg::REG_CMD_STATUS,
                      16'h0), 1'b0, '0);
      run_cmd(blk_cmd(ide_pkg::OP_BLK_WR, 8'(BUF_WORDS - 1), rnd[31:16]), 1'b0, '0);
      run_cmd(reg_cmd(ide_pkg::OP_REG_RD, ide_pkg::CS_TASKFILE, ide_pkg::REG_CMD_STATUS,
                      16'h0), 1'b0, '0);
      run_cmd(reg_cmd(ide_pkg::OP_REG_RD, ide_pkg::CS_TASKFILE, ide_pkg::REG_DATA, 16'h0),
              1'b0, '0);
      run_cmd(reg_cmd(ide_pkg::OP_REG_WR, ide_pkg::CS_TASKFILE, ide_pkg::REG_CMD_STATUS,
                      16'h0), 1'b0, '0);
      run_cmd(blk_cmd(ide_pkg::OP_BLK_RD, 8'(BUF_WORDS - 1), 16'h0), 1'b0, '0);
      run_cmd(reg_cmd(ide_pkg::OP_REG_RD, ide_pkg::CS_TASKFILE, ide_pkg::REG_CMD_STATUS,
                      16'h0), 1'b0, '0);

      // a dropped register write leaves the task file as it was.
      for (int r = 1; r <= 6; r++)
         run_cmd(reg_cmd(ide_pkg::OP_REG_RD, ide_pkg::CS_TASKFILE, 3'(r), 16'h0), 1'b0, '0);

      $display("check errors: %0d, other errors: %0d", chk_errs, misc_errs);
      if (chk_errs == 0 && misc_errs == 0)
         $display("ALL TESTS PASSED");
      else
         $display("SOME TESTS FAILED");
      $finish;
   end

endmodule
